//--- keypad_defines.svh
`ifndef KEYPAD_DEFINES_SVH
`define KEYPAD_DEFINES_SVH

// Scanner timing
`define KP_SCAN_DIV       4  // Clocks per column
`define KP_DEBOUNCE_SCANS 2  // Identical full scans to accept a change

// Longest word the buffer collects
`define KP_WORD_LEN 5

// Key codes are {row one-hot, col one-hot}, row 0 and col 0 in the top bit
`define KP_KEY_SUBMIT_LETTER 8'b0001_1000 // R3 C0
`define KP_KEY_CLEAR         8'b0001_0100 // R3 C1
`define KP_KEY_SUBMIT_WORD   8'b0001_0010 // R3 C2
`define KP_KEY_GAME_END      8'b0010_0001 // R2 C3

// Four-letter groups
`define KP_KEY_7 8'b0010_1000 // R2 C0, PQRS
`define KP_KEY_9 8'b0010_0010 // R2 C2, WXYZ

// Keys with no function
`define KP_KEY_1 8'b1000_1000 // R0 C0
`define KP_KEY_A 8'b1000_0001 // R0 C3
`define KP_KEY_B 8'b0100_0001 // R1 C3
`define KP_KEY_D 8'b0001_0001 // R3 C3

`endif

//--- keypad_pkg.sv
`include "keypad_defines.svh"

package keypad_pkg;

  // Row nibble over column nibble, zero when nothing pressed
  typedef logic [7:0] key_code_t;

  // Debounced key from the scanner
  typedef struct packed {
    key_code_t code;   // Held key, zero on release
    logic      strobe; // One cycle on a newly accepted key
  } key_event_t;

  typedef logic [7:0] letter_t; // ASCII

  // Multi-tap progress, S0..S3 give the tap index
  typedef enum logic [2:0] {
    INIT = 3'd0,
    S0   = 3'd1,
    S1   = 3'd2,
    S2   = 3'd3,
    S3   = 3'd4,
    DONE = 3'd5  // Letter committed this cycle
  } tap_state_t;

  // Collected word, letters[0] typed first
  typedef struct packed {
    letter_t [`KP_WORD_LEN-1:0] letters;
    logic    [3:0]              len;
  } word_t;

endpackage

//--- keypad_scanner.sv
`timescale 1ns/1ps
`include "keypad_defines.svh"

module keypad_scanner (
  input  logic                   clk,
  input  logic                   nRst,
  input  logic [3:0]             rows, // Row 0 in bit 3
  output logic [3:0]             cols, // Column 0 in bit 3, active high
  output keypad_pkg::key_event_t key
);
  localparam int DIV_W = (`KP_SCAN_DIV > 1) ? $clog2(`KP_SCAN_DIV) : 1;
  localparam int CNT_W = $clog2(`KP_DEBOUNCE_SCANS + 1);

  logic [DIV_W-1:0]      div_cnt;   // Cycles on current column
  logic                  col_end;   // Last cycle on this column
  logic                  scan_end;  // Last cycle of column 3
  logic [3:0]            row_hit;   // Highest-priority active row
  keypad_pkg::key_code_t scan_acc;  // First key seen so far this scan
  keypad_pkg::key_code_t scan_code; // Scan result including this cycle
  keypad_pkg::key_code_t last_scan; // Result of previous full scan
  logic [CNT_W-1:0]      same_cnt;  // Run of identical scans
  logic [CNT_W-1:0]      same_next;
  logic                  accept;    // Debounced change of key

  assign col_end  = (div_cnt == DIV_W'(`KP_SCAN_DIV - 1));
  assign scan_end = col_end && cols[0];

  // Row 0 wins if several rows are low-impedance at once
  always_comb begin
    casez (rows)
      4'b1???: row_hit = 4'b1000;
      4'b01??: row_hit = 4'b0100;
      4'b001?: row_hit = 4'b0010;
      4'b0001: row_hit = 4'b0001;
      default: row_hit = 4'b0000;
    endcase
  end

  // Earlier column keeps its hit
  always_comb begin
    scan_code = scan_acc;
    if ((scan_acc == '0) && (row_hit != '0))
      scan_code = {row_hit, cols};
  end

  // Saturating count of equal scans
  always_comb begin
    same_next = CNT_W'(1); // New run starts at one
    if (scan_code == last_scan) begin
      if (same_cnt == CNT_W'(`KP_DEBOUNCE_SCANS))
        same_next = same_cnt;
      else
        same_next = same_cnt + 1'b1;
    end
  end

  assign accept = scan_end && (same_next == CNT_W'(`KP_DEBOUNCE_SCANS)) &&
                  (scan_code != key.code);

  always_ff @(posedge clk, negedge nRst) begin
    if (~nRst) begin
      div_cnt   <= '0;
      cols      <= 4'b1000; // Column 0 first
      scan_acc  <= '0;
      last_scan <= '0;
      same_cnt  <= '0;
      key       <= '0;
    end else begin
      key.strobe <= 1'b0;
      div_cnt    <= col_end ? '0 : div_cnt + 1'b1;
      if (col_end) begin
        cols     <= {cols[0], cols[3:1]};     // Next column, wraps to 0
        scan_acc <= scan_end ? '0 : scan_code; // Rows sampled late in column
      end
      if (scan_end) begin
        last_scan <= scan_code;
        same_cnt  <= same_next;
      end
      if (accept) begin
        key.code   <= scan_code;
        key.strobe <= (scan_code != '0); // Release is silent
      end
    end
  end

  cols_onehot_a: assert property (@(posedge clk) disable iff (~nRst) $onehot(cols));

endmodule

//--- keypad_fsm.sv
`timescale 1ns/1ps
`include "keypad_defines.svh"

module keypad_fsm (
  input  logic                   clk,
  input  logic                   nRst,
  input  keypad_pkg::key_event_t key,
  output logic                   letter_valid, // High during DONE
  output logic                   word_submit,  // Same cycle as strobe
  output logic                   game_end,     // Same cycle as strobe
  output keypad_pkg::letter_t    letter        // Pending or committed letter
);
  keypad_pkg::tap_state_t state, next_state;
  keypad_pkg::key_code_t  last_key, next_last; // Last letter key tapped
  keypad_pkg::letter_t    next_letter;
  keypad_pkg::tap_state_t tap;                 // Tap state for a letter key

  logic is_commit, is_clear, is_word, is_end;
  logic is_invalid, is_letter, four_tap;

  // First letter of the group plus tap index
  function automatic keypad_pkg::letter_t to_ascii(input logic [3:0] row,
                                                   input logic [3:0] col,
                                                   input keypad_pkg::tap_state_t st);
    keypad_pkg::letter_t base;
    base = '0;
    case (row)
      4'b1000: begin // Row 0
        if (col[2])
          base = 8'h41; // A
        else if (col[1])
          base = 8'h44; // D
      end
      4'b0100: begin // Row 1
        if (col[3])
          base = 8'h47; // G
        else if (col[2])
          base = 8'h4A; // J
        else if (col[1])
          base = 8'h4D; // M
      end
      4'b0010: begin // Row 2
        if (col[3])
          base = 8'h50; // P
        else if (col[2])
          base = 8'h54; // T
        else if (col[1])
          base = 8'h57; // W
      end
      default: base = '0;
    endcase
    // S0 encodes 1, so index is state minus one
    if (st inside {keypad_pkg::S0, keypad_pkg::S1, keypad_pkg::S2, keypad_pkg::S3})
      base = base + {5'd0, st} - 8'd1;
    return base;
  endfunction

  // Next tap on the same key
  function automatic keypad_pkg::tap_state_t advance(input keypad_pkg::tap_state_t st,
                                                     input logic four);
    case (st)
      keypad_pkg::S0: return keypad_pkg::S1;
      keypad_pkg::S1: return keypad_pkg::S2;
      keypad_pkg::S2: return four ? keypad_pkg::S3 : keypad_pkg::S0;
      default:        return keypad_pkg::S0; // S3 wraps, INIT/DONE restart
    endcase
  endfunction

  assign is_commit  = (key.code == `KP_KEY_SUBMIT_LETTER);
  assign is_clear   = (key.code == `KP_KEY_CLEAR);
  assign is_word    = (key.code == `KP_KEY_SUBMIT_WORD);
  assign is_end     = (key.code == `KP_KEY_GAME_END);
  assign is_invalid = (key.code inside {`KP_KEY_1, `KP_KEY_A, `KP_KEY_B, `KP_KEY_D});
  assign is_letter  = (key.code != '0) && !is_commit && !is_clear && !is_word &&
                      !is_end && !is_invalid;
  assign four_tap   = (key.code == `KP_KEY_7) || (key.code == `KP_KEY_9);

  // Repeat tap only while a letter is pending
  assign tap = ((key.code == last_key) && (state != keypad_pkg::INIT) &&
                (state != keypad_pkg::DONE)) ? advance(state, four_tap) : keypad_pkg::S0;

  assign letter_valid = (state == keypad_pkg::DONE);
  assign word_submit  = key.strobe && is_word;
  assign game_end     = key.strobe && is_end;

  always_comb begin
    next_state  = state;
    next_letter = letter;
    next_last   = last_key;
    if (state == keypad_pkg::DONE) begin // Commit lasts one cycle
      next_state  = keypad_pkg::INIT;
      next_letter = '0;
    end
    if (key.strobe) begin
      if (is_commit) begin
        if (state inside {keypad_pkg::S0, keypad_pkg::S1, keypad_pkg::S2, keypad_pkg::S3})
          next_state = keypad_pkg::DONE; // Letter held for the commit cycle
      end else if (is_clear || is_word || is_end) begin
        next_state  = keypad_pkg::INIT;
        next_letter = '0;
        next_last   = '0; // Forget key so the next tap starts fresh
      end else if (is_letter) begin
        next_state  = tap;
        next_letter = to_ascii(key.code[7:4], key.code[3:0], tap);
        next_last   = key.code;
      end
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (~nRst) begin
      state    <= keypad_pkg::INIT;
      last_key <= '0;
      letter   <= '0;
    end else begin
      state    <= next_state;
      last_key <= next_last;
      letter   <= next_letter;
    end
  end

  // DONE always falls back to INIT
  commit_single_a: assert property (@(posedge clk) disable iff (~nRst)
    letter_valid |=> !letter_valid);

  submit_end_excl_a: assert property (@(posedge clk) disable iff (~nRst)
    !(word_submit && game_end));

endmodule

//--- word_buffer.sv
`timescale 1ns/1ps
`include "keypad_defines.svh"

module word_buffer (
  input  logic                clk,
  input  logic                nRst,
  input  logic                letter_valid, // Commit pulse
  input  logic                word_submit,
  input  logic                game_end,
  input  keypad_pkg::letter_t letter,
  output keypad_pkg::word_t   word,         // Valid with word_valid
  output logic                word_valid
);
  keypad_pkg::word_t work;     // Word being typed
  keypad_pkg::word_t work_app; // Work plus this cycle's letter
  logic              room;     // Space for another letter

  assign room = (work.len < 4'(`KP_WORD_LEN));

  // Append in place, overflow dropped
  always_comb begin
    work_app = work;
    if (letter_valid && room) begin
      work_app.letters[work.len] = letter;
      work_app.len               = work.len + 4'd1;
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (~nRst) begin
      work       <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= word_submit; // One cycle after submit
      if (word_submit || game_end)
        work <= '0; // Next word starts empty
      else
        work <= work_app;
    end
  end

  // Snapshot includes a letter committed in the submit cycle
  always_ff @(posedge clk) begin
    if (word_submit)
      word <= work_app;
  end

  len_bound_a: assert property (@(posedge clk) disable iff (~nRst)
    work.len <= 4'(`KP_WORD_LEN));

endmodule

//--- keypad_top.sv
`timescale 1ns/1ps

module keypad_top (
  input  logic                clk,
  input  logic                nRst,
  input  logic [3:0]          rows,
  output logic [3:0]          cols,
  output logic                letter_valid,
  output keypad_pkg::letter_t letter,
  output logic                game_end,
  output keypad_pkg::word_t   word,
  output logic                word_valid
);
  keypad_pkg::key_event_t key;         // Debounced key and strobe
  logic                   word_submit; // FSM to buffer only

  keypad_scanner u_scanner (
    .clk  (clk),
    .nRst (nRst),
    .rows (rows),
    .cols (cols),
    .key  (key)
  );

  keypad_fsm u_fsm (
    .clk          (clk),
    .nRst         (nRst),
    .key          (key),
    .letter_valid (letter_valid),
    .word_submit  (word_submit),
    .game_end     (game_end),
    .letter       (letter)
  );

  word_buffer u_word_buffer (
    .clk          (clk),
    .nRst         (nRst),
    .letter_valid (letter_valid),
    .word_submit  (word_submit),
    .game_end     (game_end),
    .letter       (letter),
    .word         (word),
    .word_valid   (word_valid)
  );

endmodule

//--- tb_keypad.sv
`timescale 1ns/1ps
`include "keypad_defines.svh"

module tb_keypad;
  localparam int HOLD         = (`KP_DEBOUNCE_SCANS + 2) * 4 * `KP_SCAN_DIV; // Cycles per hold
  localparam int NUM_PRESSES  = 300;
  localparam int NUM_DIRECTED = 33;
  localparam int TIMEOUT      = (NUM_DIRECTED + NUM_PRESSES) * 2 * HOLD * 6 / 5; // 20 % margin

  logic                clk;
  logic                nRst;
  logic [3:0]          rows;
  logic [3:0]          cols;
  logic                letter_valid;
  keypad_pkg::letter_t letter;
  logic                game_end;
  keypad_pkg::word_t   word;
  logic                word_valid;

  // Pulses seen during one press and release
  int                  lv_cnt, ge_cnt, wv_cnt;
  keypad_pkg::letter_t lv_letter;
  keypad_pkg::word_t   wv_word;

  // Reference model state
  bit                    pend_act;    // Letter pending, S0..S3
  int                    pend_idx;
  keypad_pkg::key_code_t last_code;   // Last letter key
  keypad_pkg::letter_t   pend_letter;
  keypad_pkg::word_t     exp_word;
  int                    cycles;
  int                    letter_keys[8] = '{1, 2, 4, 5, 6, 8, 9, 10}; // Index is row*4+col

  // Tap wrap, overflow, game end and clear sequences ahead of the random run
  int directed_keys[NUM_DIRECTED] = '{
    8, 8, 8, 8, 8, 12,    // P Q R S wraps to P
    1, 1, 1, 1, 12,       // A B C wraps to A
    10, 10, 10, 10, 12,   // W X Y Z
    4, 12, 5, 12, 6, 12,  // G J M, M falls off the end
    14,
    9, 12, 11,            // T thrown away by game end
    5, 13, 12,            // Cleared so commit does nothing
    2, 2, 12, 14          // E alone
  };

  keypad_top UUT (
    .clk          (clk),
    .nRst         (nRst),
    .rows         (rows),
    .cols         (cols),
    .letter_valid (letter_valid),
    .letter       (letter),
    .game_end     (game_end),
    .word         (word),
    .word_valid   (word_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT)
      report_fail("Timeout, the run did not finish within the cycle limit");
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_letter(input string name, input keypad_pkg::letter_t got,
                              input keypad_pkg::letter_t exp);
    if (got !== exp)
      report_fail($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_word(input string name, input keypad_pkg::word_t got,
                            input keypad_pkg::word_t exp);
    if (got !== exp)
      report_fail($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_fail($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // At most one pulse per press, and only when expected
  task automatic check_pulse_count(input string name, input int count, input bit expected);
    if (count > 1)
      report_fail($sformatf("%s pulsed %0d times for one key press", name, count));
    else if (expected && (count == 0))
      report_fail($sformatf("Expected %s pulse never arrived", name));
    else
      check_flag(name, count == 1, expected);
  endtask

  function automatic keypad_pkg::key_code_t code_of(input int k);
    return {4'b1000 >> (k / 4), 4'b1000 >> (k % 4)};
  endfunction

  // First letter of each multi-tap group, zero for other keys
  function automatic keypad_pkg::letter_t group_base(input int k);
    case (k)
      1:       return "A";
      2:       return "D";
      4:       return "G";
      5:       return "J";
      6:       return "M";
      8:       return "P";
      9:       return "T";
      10:      return "W";
      default: return 8'h00;
    endcase
  endfunction

  // Pressed switch connects the driven column to its row
  function automatic logic [3:0] matrix_rows(input bit down, input int k,
                                             input logic [3:0] col_drive);
    if (down && col_drive[3 - (k % 4)])
      return 4'b1000 >> (k / 4);
    return 4'b0000;
  endfunction

  // Hold then release one key, counting output pulses at each falling edge
  task automatic press_key(input int k);
    lv_cnt = 0;
    ge_cnt = 0;
    wv_cnt = 0;
    for (int i = 0; i < 2 * HOLD; i++) begin
      @(negedge clk);
      if (letter_valid) begin
        lv_cnt++;
        lv_letter = letter;
      end
      if (game_end)
        ge_cnt++;
      if (word_valid) begin
        wv_cnt++;
        wv_word = word;
      end
      rows = matrix_rows(i < HOLD, k, cols);
    end
  endtask

  // Apply the entry and word rules to one press, then compare
  task automatic model_and_check(input int k);
    keypad_pkg::key_code_t code;
    bit                    exp_lv, exp_ge, exp_wv;
    int                    size;
    code   = code_of(k);
    exp_lv = 1'b0;
    exp_ge = 1'b0;
    exp_wv = 1'b0;
    if (group_base(k) != 8'h00) begin
      size = ((code == `KP_KEY_7) || (code == `KP_KEY_9)) ? 4 : 3;
      pend_idx    = (pend_act && (code == last_code)) ? (pend_idx + 1) % size : 0;
      pend_act    = 1'b1;
      last_code   = code;
      pend_letter = group_base(k) + 8'(pend_idx);
    end else if (code == `KP_KEY_SUBMIT_LETTER) begin
      if (pend_act) begin
        exp_lv = 1'b1;
        check_pulse_count("letter_valid", lv_cnt, 1'b1);
        check_letter("letter at commit", lv_letter, pend_letter);
        if (exp_word.len < `KP_WORD_LEN) begin
          exp_word.letters[exp_word.len] = pend_letter;
          exp_word.len = exp_word.len + 4'd1;
        end // Else dropped
        pend_act = 1'b0;
      end
    end else if ((code == `KP_KEY_CLEAR) || (code == `KP_KEY_SUBMIT_WORD) ||
                 (code == `KP_KEY_GAME_END)) begin
      exp_wv = (code == `KP_KEY_SUBMIT_WORD);
      exp_ge = (code == `KP_KEY_GAME_END);
      if (exp_wv) begin
        check_pulse_count("word_valid", wv_cnt, 1'b1);
        check_word("word", wv_word, exp_word);
      end
      if (exp_wv || exp_ge)
        exp_word = '0; // Next word starts empty
      pend_act  = 1'b0;
      last_code = '0;
    end // Invalid keys change nothing
    check_pulse_count("letter_valid", lv_cnt, exp_lv);
    check_pulse_count("game_end", ge_cnt, exp_ge);
    check_pulse_count("word_valid", wv_cnt, exp_wv);
    check_letter("letter", letter, pend_act ? pend_letter : 8'h00); // Pending after release
  endtask

  initial begin
    int w;
    int k;
    void'($urandom(32'ha665_7e92));
    nRst        = 1'b0;
    rows        = 4'b0000;
    cycles      = 0;
    pend_act    = 1'b0;
    pend_idx    = 0;
    last_code   = '0;
    pend_letter = '0;
    exp_word    = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    nRst = 1'b1;
    check_flag("cols[3]", cols[3], 1'b1);
    check_flag("cols one-hot", $onehot(cols), 1'b1);
    check_flag("letter_valid", letter_valid, 1'b0);
    check_flag("word_valid", word_valid, 1'b0);
    check_flag("game_end", game_end, 1'b0);
    check_letter("letter", letter, 8'h00);
    for (int d = 0; d < NUM_DIRECTED; d++) begin
      press_key(directed_keys[d]);
      model_and_check(directed_keys[d]);
    end
    for (int p = 0; p < NUM_PRESSES; p++) begin
      w = $urandom % 32;
      if (w < 18)
        k = letter_keys[$urandom % 8];
      else if (w < 23)
        k = 12; // Commit
      else if (w == 23)
        k = 13; // Clear
      else if (w == 24)
        k = 14; // Submit word
      else if (w == 25)
        k = 11; // Game end
      else
        k = $urandom % 16; // Any key, invalid ones too
      press_key(k);
      model_and_check(k);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- project.f
+incdir+.
keypad_pkg.sv
keypad_scanner.sv
keypad_fsm.sv
word_buffer.sv
keypad_top.sv
tb_keypad.sv
